// File: Bender.yml
package:
  name: hart_sched

sources:
  - rtl/hart_pkg.sv
  - rtl/hart_event_capture.sv
  - rtl/hart_state.sv
  - rtl/hart_status_query.sv
  - rtl/hart_sched_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_hart_sched.sv

// File: hart_sched.f
+incdir+tb
rtl/hart_pkg.sv
rtl/hart_event_capture.sv
rtl/hart_state.sv
rtl/hart_status_query.sv
rtl/hart_sched_top.sv
tb/tb_hart_sched.sv

// File: rtl/hart_event_capture.sv
// strobes are single-cycle and need no handshake; an id is only looked at while its strobe is high
`timescale 1ns/1ns

module hart_event_capture (
    input  logic                    clk,
    input  logic                    rst,

    // decode stage
    input  hart_pkg::hart_ctrl_op_e i_ctrl_op,
    input  hart_pkg::hart_id_t      i_ctrl_hid,

    // fetch stage
    input  logic                    i_ic_miss,
    input  hart_pkg::hart_id_t      i_issue_hid,
    input  logic                    i_ic_fin,
    input  hart_pkg::hart_id_t      i_ic_fin_hid,

    // memory stage
    input  logic                    i_dc_miss,
    input  hart_pkg::hart_id_t      i_ex_hid,
    input  logic                    i_dc_fin,
    input  hart_pkg::hart_id_t      i_dc_fin_hid,

    // switch logic stall levels
    input  logic                    i_ic_stall,
    input  logic                    i_dc_stall,

    output hart_pkg::hart_event_t   o_event
);
    import hart_pkg::*;

    hart_event_t event_d;
    logic        ctrl_valid;

    // id to one-hot, all zero when not enabled
    function automatic hart_mask_t hid_to_mask(input hart_id_t hid, input logic en);
        hart_mask_t mask;
        mask = '0;
        mask[hid] = en;
        return mask;
    endfunction

    assign ctrl_valid = (i_ctrl_op != HC_NONE);

    always_comb begin
        event_d.ctrl_op      = i_ctrl_op;
        event_d.ctrl_mask    = hid_to_mask(i_ctrl_hid, ctrl_valid);
        event_d.ic_miss_mask = hid_to_mask(i_issue_hid, i_ic_miss);
        event_d.dc_miss_mask = hid_to_mask(i_ex_hid, i_dc_miss);
        event_d.ic_fin_mask  = hid_to_mask(i_ic_fin_hid, i_ic_fin);
        event_d.dc_fin_mask  = hid_to_mask(i_dc_fin_hid, i_dc_fin);
        // either stall source freezes the primary hart
        event_d.stall        = i_ic_stall | i_dc_stall;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_event.ctrl_op      <= HC_NONE;
            o_event.ctrl_mask    <= '0;
            o_event.ic_miss_mask <= '0;
            o_event.dc_miss_mask <= '0;
            o_event.ic_fin_mask  <= '0;
            o_event.dc_fin_mask  <= '0;
            o_event.stall        <= 1'b0;
        end else begin
            o_event <= event_d;
        end
    end

    // each mask names one hart at most
    a_event_onehot : assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(o_event.ctrl_mask) && $onehot0(o_event.ic_miss_mask) &&
        $onehot0(o_event.dc_miss_mask) && $onehot0(o_event.ic_fin_mask) &&
        $onehot0(o_event.dc_fin_mask)
    );

endmodule

// File: rtl/hart_pkg.sv
// four harts only; the mask coding and the lowest-index pick assume HART_NUM is 4
package hart_pkg;

    // hart count and id width
    localparam int HART_NUM  = 4;
    localparam int HART_ID_W = 2;

    typedef logic [HART_ID_W-1:0] hart_id_t;

    // bit n belongs to hart n
    typedef logic [HART_NUM-1:0] hart_mask_t;

    // hart 0 runs out of reset, the rest wait for a start
    localparam hart_mask_t RST_ACTIVE = 4'b0001;
    localparam hart_mask_t RST_IDLE   = 4'b1110;

    // hart-control opcode from decode
    typedef enum logic [1:0] {
        HC_NONE  = 2'd0,
        HC_START = 2'd1,
        HC_KILL  = 2'd2
    } hart_ctrl_op_e;

    // status answered by the query port
    typedef enum logic [1:0] {
        HV_IDLE   = 2'd0,
        HV_ACTIVE = 2'd1,
        HV_PEND   = 2'd2
    } hart_val_e;

    // one cycle of decoded events, 23 bits
    typedef struct packed {
        hart_ctrl_op_e ctrl_op;
        // target of the start or kill
        hart_mask_t    ctrl_mask;
        hart_mask_t    ic_miss_mask;
        hart_mask_t    dc_miss_mask;
        hart_mask_t    ic_fin_mask;
        hart_mask_t    dc_fin_mask;
        // either switch stall level
        logic          stall;
    } hart_event_t;

endpackage

// File: rtl/hart_sched_top.sv
// four-hart scheduler; events reach the masks after 2 edges, queries answer after 1
`timescale 1ns/1ns

module hart_sched_top (
    input  logic                    clk,
    input  logic                    rst,

    // decode stage hart control
    input  hart_pkg::hart_ctrl_op_e i_ctrl_op,
    input  hart_pkg::hart_id_t      i_ctrl_hid,

    // fetch stage cache events
    input  logic                    i_ic_miss,
    input  hart_pkg::hart_id_t      i_issue_hid,
    input  logic                    i_ic_fin,
    input  hart_pkg::hart_id_t      i_ic_fin_hid,

    // memory stage cache events
    input  logic                    i_dc_miss,
    input  hart_pkg::hart_id_t      i_ex_hid,
    input  logic                    i_dc_fin,
    input  hart_pkg::hart_id_t      i_dc_fin_hid,

    // from the hart switch logic
    input  logic                    i_ic_stall,
    input  logic                    i_dc_stall,

    // status lookup
    input  hart_pkg::hart_id_t      i_query_hid,

    output hart_pkg::hart_mask_t    o_idle_mask,
    output hart_pkg::hart_mask_t    o_active_mask,
    output hart_pkg::hart_mask_t    o_prim_mask,
    output hart_pkg::hart_val_e     o_query_val,
    output logic                    o_query_idle
);
    import hart_pkg::*;

    hart_event_t event_q;
    hart_mask_t  idle_mask;
    hart_mask_t  active_mask;
    hart_mask_t  prim_mask;

    hart_event_capture u_capture (
        .clk          (clk),
        .rst          (rst),
        .i_ctrl_op    (i_ctrl_op),
        .i_ctrl_hid   (i_ctrl_hid),
        .i_ic_miss    (i_ic_miss),
        .i_issue_hid  (i_issue_hid),
        .i_ic_fin     (i_ic_fin),
        .i_ic_fin_hid (i_ic_fin_hid),
        .i_dc_miss    (i_dc_miss),
        .i_ex_hid     (i_ex_hid),
        .i_dc_fin     (i_dc_fin),
        .i_dc_fin_hid (i_dc_fin_hid),
        .i_ic_stall   (i_ic_stall),
        .i_dc_stall   (i_dc_stall),
        .o_event      (event_q)
    );

    hart_state u_state (
        .clk           (clk),
        .rst           (rst),
        .i_event       (event_q),
        .o_idle_mask   (idle_mask),
        .o_active_mask (active_mask),
        .o_prim_mask   (prim_mask)
    );

    hart_status_query u_query (
        .clk           (clk),
        .rst           (rst),
        .i_idle_mask   (idle_mask),
        .i_active_mask (active_mask),
        .i_prim_mask   (prim_mask),
        .i_query_hid   (i_query_hid),
        .o_idle_mask   (o_idle_mask),
        .o_active_mask (o_active_mask),
        .o_prim_mask   (o_prim_mask),
        .o_query_val   (o_query_val),
        .o_query_idle  (o_query_idle)
    );

endmodule

// File: rtl/hart_state.sv
// lowest-index switch only; a refill must not complete for a hart that was killed meanwhile
`timescale 1ns/1ns

module hart_state (
    input  logic                  clk,
    input  logic                  rst,

    // registered events from the capture stage
    input  hart_pkg::hart_event_t i_event,

    output hart_pkg::hart_mask_t  o_idle_mask,
    output hart_pkg::hart_mask_t  o_active_mask,
    output hart_pkg::hart_mask_t  o_prim_mask
);
    import hart_pkg::*;

    hart_mask_t start_mask;
    hart_mask_t kill_mask;
    logic       target_idle;
    hart_mask_t next_active;
    hart_mask_t switch_cand;
    hart_mask_t next_prim;
    logic       prim_hit;

    // start and kill split out of the control word
    assign start_mask = (i_event.ctrl_op == HC_START) ? i_event.ctrl_mask : '0;
    assign kill_mask  = (i_event.ctrl_op == HC_KILL)  ? i_event.ctrl_mask : '0;

    // target hart currently not started
    assign target_idle = |(i_event.ctrl_mask & o_idle_mask);

    // active mask update, order matters
    always_comb begin
        next_active = o_active_mask;
        // refills first
        next_active = next_active | i_event.ic_fin_mask;
        next_active = next_active | i_event.dc_fin_mask;
        // then misses
        next_active = next_active & ~i_event.ic_miss_mask;
        next_active = next_active & ~i_event.dc_miss_mask;
        // hart control last
        if ((start_mask != '0) && target_idle) begin
            next_active = next_active | start_mask;
        end else if ((kill_mask != '0) && !target_idle) begin
            next_active = next_active & ~kill_mask;
        end
    end

    // other active harts, excluding the current owner
    assign switch_cand = next_active & ~o_prim_mask;

    // keep only the lowest set bit
    assign next_prim = switch_cand & (~switch_cand + 1'b1);

    // owner loses the slot on its own miss or kill
    assign prim_hit = |(o_prim_mask &
                        (i_event.ic_miss_mask | i_event.dc_miss_mask | kill_mask));

    always_ff @(posedge clk) begin
        if (rst) begin
            o_active_mask <= RST_ACTIVE;
        end else begin
            o_active_mask <= next_active;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_idle_mask <= RST_IDLE;
        end else if (start_mask != '0) begin
            o_idle_mask <= o_idle_mask & ~start_mask;
        end else if (kill_mask != '0) begin
            o_idle_mask <= o_idle_mask | kill_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_prim_mask <= RST_ACTIVE;
        end else if (i_event.stall) begin
            // frozen by the switch logic
            o_prim_mask <= o_prim_mask;
        end else if (o_prim_mask == '0) begin
            // no owner, first refill takes the slot
            if (i_event.ic_fin_mask != '0) begin
                o_prim_mask <= i_event.ic_fin_mask;
            end else if (i_event.dc_fin_mask != '0) begin
                o_prim_mask <= i_event.dc_fin_mask;
            end
        end else if (prim_hit) begin
            // zero when nobody else can run
            o_prim_mask <= next_prim;
        end
    end

    // at most one owner of the issue slot
    a_prim_onehot : assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(o_prim_mask)
    );

    // a started hart is never also idle
    a_active_idle_disjoint : assert property (
        @(posedge clk) disable iff (rst)
        (o_active_mask & o_idle_mask) == '0
    );

endmodule

// File: rtl/hart_status_query.sv
// all outputs registered; a query answers from the masks seen in the same cycle as its id
`timescale 1ns/1ns

module hart_status_query (
    input  logic                   clk,
    input  logic                   rst,

    // masks from the state unit
    input  hart_pkg::hart_mask_t   i_idle_mask,
    input  hart_pkg::hart_mask_t   i_active_mask,
    input  hart_pkg::hart_mask_t   i_prim_mask,

    // hart to look up
    input  hart_pkg::hart_id_t     i_query_hid,

    output hart_pkg::hart_mask_t   o_idle_mask,
    output hart_pkg::hart_mask_t   o_active_mask,
    output hart_pkg::hart_mask_t   o_prim_mask,
    output hart_pkg::hart_val_e    o_query_val,
    output logic                   o_query_idle
);
    import hart_pkg::*;

    logic      sel_idle;
    logic      sel_active;
    hart_val_e query_val_d;

    // bits of the queried hart
    assign sel_idle   = i_idle_mask[i_query_hid];
    assign sel_active = i_active_mask[i_query_hid];

    // idle wins over active, pending is the rest
    always_comb begin
        if (sel_idle) begin
            query_val_d = HV_IDLE;
        end else if (sel_active) begin
            query_val_d = HV_ACTIVE;
        end else begin
            query_val_d = HV_PEND;
        end
    end

    // published masks match the state unit reset values
    always_ff @(posedge clk) begin
        if (rst) begin
            o_idle_mask   <= RST_IDLE;
            o_active_mask <= RST_ACTIVE;
            o_prim_mask   <= RST_ACTIVE;
        end else begin
            o_idle_mask   <= i_idle_mask;
            o_active_mask <= i_active_mask;
            o_prim_mask   <= i_prim_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_query_val  <= HV_IDLE;
            o_query_idle <= 1'b1;
        end else begin
            o_query_val  <= query_val_d;
            o_query_idle <= sel_idle;
        end
    end

endmodule

// File: tb/hart_sched_vectors.svh
// rows build on each other from reset; expected masks assume lowest-index switching of 4 harts
`ifndef HART_SCHED_VECTORS_SVH
`define HART_SCHED_VECTORS_SVH

// inputs applied for one cycle, expected state seen 3 edges later
typedef struct packed {
    hart_ctrl_op_e ctrl_op;
    hart_id_t      ctrl_hid;
    logic          ic_miss;
    hart_id_t      issue_hid;
    logic          dc_miss;
    hart_id_t      ex_hid;
    logic          ic_fin;
    hart_id_t      ic_fin_hid;
    logic          dc_fin;
    hart_id_t      dc_fin_hid;
    logic          ic_stall;
    logic          dc_stall;
    hart_id_t      query_hid;
    hart_mask_t    exp_idle;
    hart_mask_t    exp_active;
    hart_mask_t    exp_prim;
    hart_val_e     exp_val;
} stim_row_t;

localparam int NUM_ROWS = 14;

// columns: op, hid, ic_miss, issue_hid, dc_miss, ex_hid, ic_fin, hid, dc_fin, hid,
// ic_stall, dc_stall, query_hid, then expected idle, active, primary and query value
localparam stim_row_t ROWS [NUM_ROWS] = '{
    // quiet cycle, hart 2 still idle
    '{HC_NONE,  2'd0, 1'b0, 2'd0, 1'b0, 2'd0, 1'b0, 2'd0, 1'b0, 2'd0, 1'b0, 1'b0,
      2'd2, 4'b1110, 4'b0001, 4'b0001, HV_IDLE},
    '{HC_START, 2'd1, 1'b0, 2'd0, 1'b0, 2'd0, 1'b0, 2'd0, 1'b0, 2'd0, 1'b0, 1'b0,
      2'd1, 4'b1100, 4'b0011, 4'b0001, HV_ACTIVE},
    '{HC_START, 2'd2, 1'b0, 2'd0, 1'b0, 2'd0, 1'b0, 2'd0, 1'b0, 2'd0, 1'b0, 1'b0,
      2'd1, 4'b1000, 4'b0111, 4'b0001, HV_ACTIVE},
    // fetch miss on the owner, hart 1 takes over
    '{HC_NONE,  2'd0, 1'b1, 2'd0, 1'b0, 2'd0, 1'b0, 2'd0, 1'b0, 2'd0, 1'b0, 1'b0,
      2'd0, 4'b1000, 4'b0110, 4'b0010, HV_PEND},
    // stalled, owner stays put
    '{HC_NONE,  2'd0, 1'b0, 2'd0, 1'b1, 2'd1, 1'b0, 2'd0, 1'b0, 2'd0, 1'b0, 1'b1,
      2'd1, 4'b1000, 4'b0100, 4'b0010, HV_PEND},
    '{HC_NONE,  2'd0, 1'b0, 2'd0, 1'b1, 2'd1, 1'b0, 2'd0, 1'b0, 2'd0, 1'b0, 1'b0,
      2'd2, 4'b1000, 4'b0100, 4'b0100, HV_ACTIVE},
    // nobody left to run
    '{HC_NONE,  2'd0, 1'b1, 2'd2, 1'b0, 2'd0, 1'b0, 2'd0, 1'b0, 2'd0, 1'b0, 1'b0,
      2'd2, 4'b1000, 4'b0000, 4'b0000, HV_PEND},
    '{HC_NONE,  2'd0, 1'b0, 2'd0, 1'b0, 2'd0, 1'b1, 2'd0, 1'b0, 2'd0, 1'b0, 1'b0,
      2'd0, 4'b1000, 4'b0001, 4'b0001, HV_ACTIVE},
    '{HC_NONE,  2'd0, 1'b0, 2'd0, 1'b0, 2'd0, 1'b0, 2'd0, 1'b1, 2'd1, 1'b0, 1'b0,
      2'd1, 4'b1000, 4'b0011, 4'b0001, HV_ACTIVE},
    // kill of the owner
    '{HC_KILL,  2'd0, 1'b0, 2'd0, 1'b0, 2'd0, 1'b0, 2'd0, 1'b0, 2'd0, 1'b0, 1'b0,
      2'd0, 4'b1001, 4'b0010, 4'b0010, HV_IDLE},
    '{HC_KILL,  2'd2, 1'b0, 2'd0, 1'b0, 2'd0, 1'b0, 2'd0, 1'b0, 2'd0, 1'b0, 1'b0,
      2'd2, 4'b1101, 4'b0010, 4'b0010, HV_IDLE},
    // fetch stall keeps the owner through its own miss
    '{HC_START, 2'd3, 1'b1, 2'd1, 1'b0, 2'd0, 1'b0, 2'd0, 1'b0, 2'd0, 1'b1, 1'b0,
      2'd3, 4'b0101, 4'b1000, 4'b0010, HV_ACTIVE},
    '{HC_NONE,  2'd0, 1'b1, 2'd1, 1'b0, 2'd0, 1'b0, 2'd0, 1'b0, 2'd0, 1'b0, 1'b0,
      2'd1, 4'b0101, 4'b1000, 4'b1000, HV_PEND},
    // refill and miss together, refill first
    '{HC_NONE,  2'd0, 1'b0, 2'd0, 1'b1, 2'd3, 1'b1, 2'd1, 1'b0, 2'd0, 1'b0, 1'b0,
      2'd3, 4'b0101, 4'b0010, 4'b0010, HV_PEND}
};

`endif

// File: tb/tb_hart_sched.sv
// table-driven; each row is checked 3 edges after it is applied, and rows depend on earlier ones
`timescale 1ns/1ns

module tb_hart_sched;
    import hart_pkg::*;

    `include "hart_sched_vectors.svh"

    localparam int HALF_PERIOD = 50;
    localparam int PERIOD      = 2 * HALF_PERIOD;
    // sample point after the edge
    localparam int SETTLE      = 10;
    localparam int RUN_LIMIT   = (NUM_ROWS + 10) * 5 * PERIOD;

    logic          clk = 1'b0;
    logic          rst;
    hart_ctrl_op_e ctrl_op;
    hart_id_t      ctrl_hid;
    logic          ic_miss;
    hart_id_t      issue_hid;
    logic          ic_fin;
    hart_id_t      ic_fin_hid;
    logic          dc_miss;
    hart_id_t      ex_hid;
    logic          dc_fin;
    hart_id_t      dc_fin_hid;
    logic          ic_stall;
    logic          dc_stall;
    hart_id_t      query_hid;
    hart_mask_t    idle_mask;
    hart_mask_t    active_mask;
    hart_mask_t    prim_mask;
    hart_val_e     query_val;
    logic          query_idle;
    int            row;

    hart_sched_top dut0 (
        .clk           (clk),
        .rst           (rst),
        .i_ctrl_op     (ctrl_op),
        .i_ctrl_hid    (ctrl_hid),
        .i_ic_miss     (ic_miss),
        .i_issue_hid   (issue_hid),
        .i_ic_fin      (ic_fin),
        .i_ic_fin_hid  (ic_fin_hid),
        .i_dc_miss     (dc_miss),
        .i_ex_hid      (ex_hid),
        .i_dc_fin      (dc_fin),
        .i_dc_fin_hid  (dc_fin_hid),
        .i_ic_stall    (ic_stall),
        .i_dc_stall    (dc_stall),
        .i_query_hid   (query_hid),
        .o_idle_mask   (idle_mask),
        .o_active_mask (active_mask),
        .o_prim_mask   (prim_mask),
        .o_query_val   (query_val),
        .o_query_idle  (query_idle)
    );

    always #HALF_PERIOD clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    // counted edges, bounded by the time they should take
    task automatic wait_cycles(input int n);
        int  count;
        time start;
        count = 0;
        start = $time;
        while (count < n) begin
            @(posedge clk);
            count++;
            if ($time - start > (n + 1) * PERIOD) begin
                report_failure("timeout: clock edges arrived later than expected");
            end
        end
    endtask

    task automatic check_hex(input string name, input logic [3:0] exp, input logic [3:0] act);
        assert (act === exp) else begin
            report_failure($sformatf("CHECK FAILED: %s expected 0x%h actual 0x%h",
                                     name, exp, act));
        end
    endtask

    task automatic apply_row(input stim_row_t r);
        ctrl_op    <= r.ctrl_op;
        ctrl_hid   <= r.ctrl_hid;
        ic_miss    <= r.ic_miss;
        issue_hid  <= r.issue_hid;
        dc_miss    <= r.dc_miss;
        ex_hid     <= r.ex_hid;
        ic_fin     <= r.ic_fin;
        ic_fin_hid <= r.ic_fin_hid;
        dc_fin     <= r.dc_fin;
        dc_fin_hid <= r.dc_fin_hid;
        ic_stall   <= r.ic_stall;
        dc_stall   <= r.dc_stall;
        query_hid  <= r.query_hid;
    endtask

    // query id stays, everything else back to no event
    task automatic clear_strobes;
        ctrl_op  <= HC_NONE;
        ic_miss  <= 1'b0;
        dc_miss  <= 1'b0;
        ic_fin   <= 1'b0;
        dc_fin   <= 1'b0;
        ic_stall <= 1'b0;
        dc_stall <= 1'b0;
    endtask

    task automatic check_row(input stim_row_t r);
        check_hex("o_idle_mask", r.exp_idle, idle_mask);
        check_hex("o_active_mask", r.exp_active, active_mask);
        check_hex("o_prim_mask", r.exp_prim, prim_mask);
        check_hex("o_query_val", {2'b00, r.exp_val}, {2'b00, query_val});
        check_hex("o_query_idle", {3'b000, r.exp_idle[r.query_hid]}, {3'b000, query_idle});
    endtask

    // backstop in case the clock stops
    initial begin
        #RUN_LIMIT;
        report_failure("timeout: run did not finish within its time limit");
    end

    initial begin
        rst <= 1'b1;
        query_hid  <= '0;
        ctrl_hid   <= '0;
        issue_hid  <= '0;
        ex_hid     <= '0;
        ic_fin_hid <= '0;
        dc_fin_hid <= '0;
        clear_strobes();
        wait_cycles(3);
        rst <= 1'b0;
        #SETTLE;
        // outputs still hold the reset values
        check_hex("o_idle_mask", RST_IDLE, idle_mask);
        check_hex("o_active_mask", RST_ACTIVE, active_mask);
        check_hex("o_prim_mask", RST_ACTIVE, prim_mask);
        check_hex("o_query_val", {2'b00, HV_IDLE}, {2'b00, query_val});
        check_hex("o_query_idle", 4'h1, {3'b000, query_idle});
        for (row = 0; row < NUM_ROWS; row++) begin
            wait_cycles(1);
            apply_row(ROWS[row]);
            wait_cycles(1);
            clear_strobes();
            wait_cycles(2);
            #SETTLE;
            check_row(ROWS[row]);
        end
        $display("test passed");
        $finish;
    end

endmodule
